// File: soc_bus.f
bus_pkg.sv
io_pkg.sv
bus_controller.sv
vector_rom.sv
scratch_ram.sv
io_controller.sv
soc_bus.sv
soc_bus_tb.sv

// File: run.sh
#!/bin/sh
# build and run the soc_bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module soc_bus_tb -f soc_bus.f -o soc_bus_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/soc_bus_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0

// File: soc_bus_tb.sv
module soc_bus_tb;

  import bus_pkg::*;
  import io_pkg::*;

  localparam int ram_addr_w   = 12;
  localparam int ram_words    = 2 ** ram_addr_w;
  localparam int clk_period   = 100;
  localparam int reset_cycles = 16;

  // test lengths in bus accesses, each access takes up to about 6 cycles
  localparam int access_cycles = 6;
  localparam int t1_accesses   = 4;
  localparam int t2_accesses   = 40;
  localparam int t3_accesses   = 15;
  localparam int t4_accesses   = 13;
  localparam int t5_accesses   = 12;
  localparam int test_cycles   = reset_cycles + access_cycles *
                                 (t1_accesses + t2_accesses + t3_accesses +
                                  t4_accesses + t5_accesses);
  localparam longint watchdog_time = 4 * longint'(test_cycles) * clk_period;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              map;
  logic [sw_w-1:0]   sw;
  logic [addr_w-1:0] cpu_address;
  logic              cpu_read;
  logic              cpu_write;
  logic [data_w-1:0] cpu_writedata;
  logic [be_w-1:0]   cpu_be;
  logic [data_w-1:0] cpu_readdata;
  logic              cpu_wait;
  logic [addr_w-1:0] vga_address;
  logic              vga_read;
  logic [23:0]       vga_readdata;
  logic              vga_wait;
  logic [led_w-1:0]  leds;
  cs_t               chipselect;

  // results of the last completed access of each master
  logic [data_w-1:0] cpu_rdata;
  int                cpu_latency;
  time               cpu_done_time;
  logic [23:0]       vga_rdata;
  time               vga_done_time;

  logic [15:0]       lfsr_state;
  logic [data_w-1:0] model_mem [ram_words];
  logic [be_w-1:0]   model_valid [ram_words];  // bytes written so far
  logic [led_w-1:0]  led_model;

  soc_bus #(
    .ram_addr_w(ram_addr_w)
  ) soc_bus_i (
    .clk(clk), .rst_n(rst_n), .map(map), .sw(sw),
    .cpu_address(cpu_address), .cpu_read(cpu_read), .cpu_write(cpu_write),
    .cpu_writedata(cpu_writedata), .cpu_be(cpu_be),
    .cpu_readdata(cpu_readdata), .cpu_wait(cpu_wait),
    .vga_address(vga_address), .vga_read(vga_read),
    .vga_readdata(vga_readdata), .vga_wait(vga_wait),
    .leds(leds), .chipselect(chipselect)
  );

  always #(clk_period / 2) clk = ~clk;

  task automatic report_error(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  // taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic logic [data_w-1:0] lane_mask(input logic [be_w-1:0] be_in);
    logic [data_w-1:0] m;
    for (int b = 0; b < be_w; b++) begin
      m[8*b +: 8] = {8{be_in[b]}};
    end
    return m;
  endfunction

  function automatic logic [addr_w-1:0] bus_addr(input logic [region_w-1:0] region,
                                                  input logic [ram_addr_w-1:0] word);
    logic [addr_w-1:0] a;
    a = '0;
    a[addr_w-1 -: region_w] = region;
    a[ram_addr_w+1:2] = word;
    return a;
  endfunction

  task automatic cpu_access(input logic [addr_w-1:0] addr, input logic wr,
                            input logic [data_w-1:0] data, input logic [be_w-1:0] be_in);
    int cycles;
    cycles = 0;
    @(posedge clk);
    #10;
    cpu_address   = addr;
    cpu_read      = !wr;
    cpu_write     = wr;
    cpu_writedata = data;
    cpu_be        = be_in;
    @(negedge clk);
    while (cpu_wait) begin
      cycles++;
      @(negedge clk);
    end
    cpu_rdata     = cpu_readdata;  // valid during the wait-low cycle
    cpu_latency   = cycles;
    cpu_done_time = $time;
    @(posedge clk);
    #10;
    cpu_read  = 1'b0;
    cpu_write = 1'b0;
  endtask

  task automatic vga_access(input logic [addr_w-1:0] addr);
    @(posedge clk);
    #10;
    vga_address = addr;
    vga_read    = 1'b1;
    @(negedge clk);
    while (vga_wait) begin
      @(negedge clk);
    end
    vga_rdata     = vga_readdata;
    vga_done_time = $time;
    @(posedge clk);
    #10;
    vga_read = 1'b0;
  endtask

  task automatic ram_write(input logic [ram_addr_w-1:0] word, input logic [data_w-1:0] data,
                           input logic [be_w-1:0] be_in);
    logic [data_w-1:0] m;
    m = lane_mask(be_in);
    cpu_access(bus_addr(region_ram, word), 1'b1, data, be_in);
    model_mem[word]   = (model_mem[word] & ~m) | (data & m);
    model_valid[word] = model_valid[word] | be_in;
  endtask

  // only bytes that were ever written are compared
  task automatic ram_check(input logic [ram_addr_w-1:0] word);
    logic [data_w-1:0] m;
    m = lane_mask(model_valid[word]);
    cpu_access(bus_addr(region_ram, word), 1'b0, '0, '1);
    assert ((cpu_rdata & m) == (model_mem[word] & m))
      else report_error($sformatf("ram word %0h read %h, expected %h under mask %h",
                                  word, cpu_rdata, model_mem[word], m));
  endtask

  task automatic io_write(input logic [1:0] off, input logic [data_w-1:0] data,
                          input logic [be_w-1:0] be_in);
    logic [led_w-1:0] m;
    logic [led_w-1:0] wbits;
    m     = led_w'(lane_mask(be_in));
    wbits = led_w'(data);
    cpu_access(bus_addr(region_io, ram_addr_w'(off)), 1'b1, data, be_in);
    case (off)
      io_reg_led: led_model = (led_model & ~m) | (wbits & m);
      io_reg_set: led_model = led_model | wbits;
      io_reg_clr: led_model = led_model & ~wbits;
      default:    led_model = led_model;
    endcase
  endtask

  task automatic led_check(input logic [1:0] rb_off);
    assert (leds == led_model)
      else report_error($sformatf("leds %h, expected %h", leds, led_model));
    cpu_access(bus_addr(region_io, ram_addr_w'(rb_off)), 1'b0, '0, '1);
    assert (cpu_rdata == data_w'(led_model))
      else report_error($sformatf("led read-back at offset %0d gave %h, expected %h",
                                  rb_off, cpu_rdata, led_model));
  endtask

  task automatic reset_state_and_latency();
    logic [ram_addr_w-1:0] word;
    assert (cpu_wait && vga_wait)
      else report_error($sformatf("waits after reset cpu %b vga %b", cpu_wait, vga_wait));
    assert (chipselect == cs_none)
      else report_error($sformatf("chipselect %0d after reset", chipselect));
    assert (leds == '0)
      else report_error($sformatf("leds %h after reset", leds));
    for (int i = 0; i < t1_accesses; i++) begin
      word = ram_addr_w'(random_bits(ram_addr_w));
      cpu_access(bus_addr(region_ram, word), 1'b0, '0, '1);
      assert (cpu_latency == 2)
        else report_error($sformatf("ram read took %0d wait cycles, expected 2", cpu_latency));
    end
  endtask

  task automatic ram_byte_writes();
    logic [ram_addr_w-1:0] words [20];
    logic [data_w-1:0]     data;
    logic [be_w-1:0]       be_in;
    for (int i = 0; i < 20; i++) begin
      words[i] = ram_addr_w'(random_bits(ram_addr_w));
      data     = random_bits(data_w);
      be_in    = be_w'(random_bits(be_w));
      ram_write(words[i], data, be_in);
    end
    for (int i = 0; i < 20; i++) begin
      ram_check(words[i]);
    end
  endtask

  task automatic region_map();
    logic [ram_addr_w-1:0] word;
    logic [data_w-1:0]     expect_val;
    for (int i = 0; i < 4; i++) begin
      ram_write(ram_addr_w'(i * 5), random_bits(data_w), '1);
    end
    map = 1'b1;  // region 0 is the vector table
    for (int i = 0; i < 4; i++) begin
      word       = ram_addr_w'(i * 5);
      expect_val = 32'h0000_1000 + 32'(i * 5 * 16);
      cpu_access(bus_addr(region_vect_ram, word), 1'b0, '0, '1);
      assert (cpu_rdata == expect_val)
        else report_error($sformatf("vector %0d read %h, expected %h", i * 5, cpu_rdata,
                                    expect_val));
    end
    map = 1'b0;
    for (int i = 0; i < 4; i++) begin
      word = ram_addr_w'(i * 5);
      cpu_access(bus_addr(region_vect_ram, word), 1'b0, '0, '1);
      assert (cpu_rdata == model_mem[word])
        else report_error($sformatf("region 0 word %0d read %h, expected ram %h", word,
                                    cpu_rdata, model_mem[word]));
    end
    map = 1'b1;
    // unmapped region reads zero and drops writes
    cpu_access(bus_addr(4'd7, ram_addr_w'(5)), 1'b0, '0, '1);
    assert (cpu_rdata == '0)
      else report_error($sformatf("region 7 read %h, expected 0", cpu_rdata));
    cpu_access(bus_addr(4'd7, ram_addr_w'(5)), 1'b1, ~model_mem[5], '1);
    ram_check(ram_addr_w'(5));
  endtask

  task automatic io_registers();
    @(posedge clk);
    #10;
    sw = sw_w'(random_bits(sw_w));
    cpu_access(bus_addr(region_io, ram_addr_w'(io_reg_sw)), 1'b0, '0, '1);
    assert (cpu_rdata == data_w'(sw))
      else report_error($sformatf("switch read %h, expected %h", cpu_rdata, sw));
    io_write(io_reg_led, random_bits(data_w), 4'b0001);
    led_check(io_reg_led);
    io_write(io_reg_led, random_bits(data_w), 4'b0010);
    led_check(io_reg_set);
    io_write(io_reg_led, random_bits(data_w), 4'b1111);
    led_check(io_reg_clr);
    io_write(io_reg_set, random_bits(data_w), 4'b0001);  // set ignores byte enables
    led_check(io_reg_led);
    io_write(io_reg_clr, random_bits(data_w), 4'b1111);
    led_check(io_reg_led);
    io_write(io_reg_sw, random_bits(data_w), 4'b1111);
    led_check(io_reg_led);
  endtask

  task automatic arbitration_order();
    logic [ram_addr_w-1:0] wa;
    logic [ram_addr_w-1:0] wb;
    for (int r = 0; r < 3; r++) begin
      wa = ram_addr_w'(random_bits(ram_addr_w));
      wb = wa ^ ram_addr_w'(1);
      ram_write(wa, random_bits(data_w), '1);
      ram_write(wb, random_bits(data_w), '1);
      // both masters request in the same cycle
      fork
        cpu_access(bus_addr(region_ram, wb), 1'b0, '0, '1);
        vga_access(bus_addr(region_ram, wa));
      join
      assert (vga_done_time < cpu_done_time)
        else report_error($sformatf("vga done at %0t, cpu done at %0t, vga must go first",
                                    vga_done_time, cpu_done_time));
      assert (vga_rdata == model_mem[wa][23:0])
        else report_error($sformatf("vga read %h, expected %h", vga_rdata,
                                    model_mem[wa][23:0]));
      assert (cpu_rdata == model_mem[wb])
        else report_error($sformatf("cpu read %h, expected %h", cpu_rdata, model_mem[wb]));
    end
  endtask

  initial begin
    #(watchdog_time);
    $display("watchdog expired at %0t, a bus access never completed", $time);
    $display("Test failed");
    $fatal(1, "simulation timed out");
  end

  initial begin
    lfsr_state    = 16'd1;
    rst_n         = 1'b0;
    map           = 1'b1;
    sw            = '0;
    cpu_address   = '0;
    cpu_read      = 1'b0;
    cpu_write     = 1'b0;
    cpu_writedata = '0;
    cpu_be        = '0;
    vga_address   = '0;
    vga_read      = 1'b0;
    led_model     = '0;
    for (int i = 0; i < ram_words; i++) begin
      model_mem[i]   = '0;
      model_valid[i] = '0;
    end
    repeat (reset_cycles) @(posedge clk);
    #10;
    rst_n = 1'b1;
    reset_state_and_latency();
    ram_byte_writes();
    region_map();
    io_registers();
    arbitration_order();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: soc_bus.sv
module soc_bus #(
  parameter int ram_addr_w = 12
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       map,
  input  logic [io_pkg::sw_w-1:0]    sw,
  input  logic [bus_pkg::addr_w-1:0] cpu_address,
  input  logic                       cpu_read,
  input  logic                       cpu_write,
  input  logic [bus_pkg::data_w-1:0] cpu_writedata,
  input  logic [bus_pkg::be_w-1:0]   cpu_be,
  output logic [bus_pkg::data_w-1:0] cpu_readdata,
  output logic                       cpu_wait,
  input  logic [bus_pkg::addr_w-1:0] vga_address,
  input  logic                       vga_read,
  output logic [23:0]                vga_readdata,
  output logic                       vga_wait,
  output logic [io_pkg::led_w-1:0]   leds,
  output bus_pkg::cs_t               chipselect
);

  import bus_pkg::*;

  logic [addr_w-1:0] bm_address;
  logic [data_w-1:0] bm_writedata;
  logic [data_w-1:0] bm_readdata;
  logic [be_w-1:0]   bm_be;
  logic              bm_read;
  logic              bm_write;
  logic [data_w-1:0] vect_readdata;
  logic [data_w-1:0] ram_readdata;
  logic [data_w-1:0] io_readdata;
  logic              vect_read;
  logic              ram_read;
  logic              ram_write;
  logic              io_read;
  logic              io_write;

  // per-slave strobes, nothing reaches a slave on cs_none
  assign vect_read = (chipselect == cs_vect) ? bm_read : 1'b0;
  assign ram_read  = (chipselect == cs_ram) ? bm_read : 1'b0;
  assign ram_write = (chipselect == cs_ram) ? bm_write : 1'b0;
  assign io_read   = (chipselect == cs_io) ? bm_read : 1'b0;
  assign io_write  = (chipselect == cs_io) ? bm_write : 1'b0;

  assign bm_readdata = ((chipselect == cs_vect) ? vect_readdata : '0) |
                       ((chipselect == cs_ram) ? ram_readdata : '0) |
                       ((chipselect == cs_io) ? io_readdata : '0);

  assign cpu_readdata = bm_readdata;
  assign vga_readdata = bm_readdata[23:0];  // display takes 24-bit pixels

  bus_controller bc0 (
    .clk(clk), .rst_n(rst_n), .map(map),
    .cpu_address(cpu_address), .cpu_read(cpu_read), .cpu_write(cpu_write),
    .cpu_writedata(cpu_writedata), .cpu_be(cpu_be), .cpu_wait(cpu_wait),
    .vga_address(vga_address), .vga_read(vga_read), .vga_wait(vga_wait),
    .address(bm_address), .writedata(bm_writedata), .be(bm_be),
    .read(bm_read), .write(bm_write), .chipselect(chipselect)
  );

  vector_rom rom0 (
    .clk(clk), .read(vect_read), .address(bm_address[6:2]), .readdata(vect_readdata)
  );

  scratch_ram #(
    .ram_addr_w(ram_addr_w)
  ) ram0 (
    .clk(clk), .read(ram_read), .write(ram_write),
    .address(bm_address[ram_addr_w+1:2]), .writedata(bm_writedata),
    .be(bm_be), .readdata(ram_readdata)
  );

  io_controller io0 (
    .clk(clk), .rst_n(rst_n), .read(io_read), .write(io_write),
    .address(bm_address[3:2]), .writedata(bm_writedata), .be(bm_be),
    .sw(sw), .readdata(io_readdata), .leds(leds)
  );

endmodule

// File: io_controller.sv
module io_controller (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       read,
  input  logic                       write,
  input  logic [1:0]                 address,
  input  logic [bus_pkg::data_w-1:0] writedata,
  input  logic [bus_pkg::be_w-1:0]   be,
  input  logic [io_pkg::sw_w-1:0]    sw,
  output logic [bus_pkg::data_w-1:0] readdata,
  output logic [io_pkg::led_w-1:0]   leds
);

  import bus_pkg::*;
  import io_pkg::*;

  logic [sw_w-1:0]   sw_q;       // switches, one register stage
  logic [led_w-1:0]  led_q;
  logic [data_w-1:0] lane_mask;
  logic [led_w-1:0]  led_mask;
  logic [led_w-1:0]  wbits;

  // byte enables spread out to a bit mask
  always_comb begin
    for (int b = 0; b < be_w; b++) begin
      lane_mask[8*b +: 8] = {8{be[b]}};
    end
  end

  assign led_mask = lane_mask[led_w-1:0];
  assign wbits    = writedata[led_w-1:0];

  always_ff @(posedge clk) begin
    sw_q <= sw;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      led_q <= '0;
    end else if (write) begin
      case (address)
        io_reg_led: led_q <= (led_q & ~led_mask) | (wbits & led_mask);
        io_reg_set: led_q <= led_q | wbits;
        io_reg_clr: led_q <= led_q & ~wbits;
        default:    led_q <= led_q;  // switch offset is read only
      endcase
    end
  end

  // LED, set and clear offsets all read back the LED register
  always_ff @(posedge clk) begin
    if (read) begin
      if (address == io_reg_sw) begin
        readdata <= data_w'(sw_q);
      end else begin
        readdata <= data_w'(led_q);
      end
    end
  end

  assign leds = led_q;

endmodule

// File: scratch_ram.sv
module scratch_ram #(
  parameter int ram_addr_w = 12
) (
  input  logic                       clk,
  input  logic                       read,
  input  logic                       write,
  input  logic [ram_addr_w-1:0]      address,
  input  logic [bus_pkg::data_w-1:0] writedata,
  input  logic [bus_pkg::be_w-1:0]   be,
  output logic [bus_pkg::data_w-1:0] readdata
);

  import bus_pkg::*;

  localparam int ram_words = 2 ** ram_addr_w;

  logic [data_w-1:0] mem [ram_words];

  always_ff @(posedge clk) begin
    if (write) begin
      // only the enabled lanes change
      for (int b = 0; b < be_w; b++) begin
        if (be[b]) begin
          mem[address][8*b +: 8] <= writedata[8*b +: 8];
        end
      end
    end
    if (read) begin
      readdata <= mem[address];
    end
  end

endmodule

// File: vector_rom.sv
module vector_rom (
  input  logic                       clk,
  input  logic                       read,
  input  logic [4:0]                 address,
  output logic [bus_pkg::data_w-1:0] readdata
);

  import bus_pkg::*;

  localparam int               vect_words = 32;
  localparam logic [data_w-1:0] vect_base = 32'h0000_1000;
  localparam int               vect_step  = 16;  // bytes between vectors

  logic [data_w-1:0] vect_tab [vect_words];

  // fixed contents, entry i points at base + i * 16
  for (genvar i = 0; i < vect_words; i++) begin : g_tab
    assign vect_tab[i] = vect_base + data_w'(i * vect_step);
  end

  always_ff @(posedge clk) begin
    if (read) begin
      readdata <= vect_tab[address];
    end
  end

endmodule

// File: bus_controller.sv
module bus_controller (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        map,
  input  logic [bus_pkg::addr_w-1:0]  cpu_address,
  input  logic                        cpu_read,
  input  logic                        cpu_write,
  input  logic [bus_pkg::data_w-1:0]  cpu_writedata,
  input  logic [bus_pkg::be_w-1:0]    cpu_be,
  output logic                        cpu_wait,
  input  logic [bus_pkg::addr_w-1:0]  vga_address,
  input  logic                        vga_read,
  output logic                        vga_wait,
  output logic [bus_pkg::addr_w-1:0]  address,
  output logic [bus_pkg::data_w-1:0]  writedata,
  output logic [bus_pkg::be_w-1:0]    be,
  output logic                        read,
  output logic                        write,
  output bus_pkg::cs_t                chipselect
);

  import bus_pkg::*;

  // arbiter states
  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_busy = 2'd1;  // slave strobe on the bus
  localparam logic [1:0] st_done = 2'd2;  // owner's wait released

  logic [1:0] state;
  logic       owner_vga;  // transaction belongs to the display port
  logic       cpu_req;
  logic       take_vga;
  logic       take_cpu;

  // region to chipselect, map moves region 0 between ROM and RAM
  function automatic cs_t decode(input logic [region_w-1:0] region, input logic map_sel);
    cs_t cs;
    case (region)
      region_vect_ram: cs = map_sel ? cs_vect : cs_ram;
      region_ram:      cs = cs_ram;
      region_io:       cs = cs_io;
      default:         cs = cs_none;
    endcase
    return cs;
  endfunction

  assign cpu_req  = cpu_read | cpu_write;
  assign take_vga = (state == st_idle) && vga_read;   // display port has priority
  assign take_cpu = (state == st_idle) && !vga_read && cpu_req;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= st_idle;
      owner_vga  <= 1'b0;
      read       <= 1'b0;
      write      <= 1'b0;
      chipselect <= cs_none;
    end else begin
      case (state)
        st_idle: begin
          if (take_vga) begin
            state      <= st_busy;
            owner_vga  <= 1'b1;
            read       <= 1'b1;
            write      <= 1'b0;
            chipselect <= decode(vga_address[addr_w-1 -: region_w], map);
          end else if (take_cpu) begin
            state      <= st_busy;
            owner_vga  <= 1'b0;
            read       <= cpu_read;
            write      <= cpu_write & ~cpu_read;  // a read wins if both are raised
            chipselect <= decode(cpu_address[addr_w-1 -: region_w], map);
          end
        end
        st_busy: begin
          // strobe lasts one cycle only
          read  <= 1'b0;
          write <= 1'b0;
          state <= st_done;
        end
        st_done: begin
          state      <= st_idle;
          chipselect <= cs_none;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // winner's request, held for the whole transaction
  always_ff @(posedge clk) begin
    if (take_vga) begin
      address <= vga_address;
      be      <= '1;
    end else if (take_cpu) begin
      address   <= cpu_address;
      be        <= cpu_be;
      writedata <= cpu_writedata;
    end
  end

  // wait drops only in the done cycle of the owning master
  assign cpu_wait = !((state == st_done) && !owner_vga);
  assign vga_wait = !((state == st_done) && owner_vga);

endmodule

// File: io_pkg.sv
package io_pkg;

  // word offsets, taken from address bits 3:2
  localparam logic [1:0] io_reg_sw  = 2'd0;
  localparam logic [1:0] io_reg_led = 2'd1;
  localparam logic [1:0] io_reg_set = 2'd2;  // OR into LEDs
  localparam logic [1:0] io_reg_clr = 2'd3;  // clear LED bits

  // switch and LED widths
  localparam int sw_w  = 16;
  localparam int led_w = 16;

endpackage

// File: bus_pkg.sv
package bus_pkg;

  // bus widths
  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int be_w   = 4;   // one enable per byte lane

  // width of the region field at the top of the address
  localparam int region_w = 4;

  // chipselect codes driven by the bus controller
  typedef enum logic [7:0] {
    cs_none = 8'd0,
    cs_vect = 8'd1,
    cs_ram  = 8'd3,
    cs_io   = 8'd4
  } cs_t;

  // top address nibble values
  localparam logic [region_w-1:0] region_vect_ram = 4'd0;  // vectors or RAM, per map
  localparam logic [region_w-1:0] region_ram      = 4'd3;
  localparam logic [region_w-1:0] region_io       = 4'd4;

endpackage
